// File: hw/busResponder.sv
`timescale 1ns/1ps
`default_nettype none

module busResponder
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire csrPkg::sirRsp_t ctrlRsp,
    input  wire csrPkg::sirRsp_t statusRsp,
    output csrPkg::sirRsp_t      sirRsp
);

    // ****************************************
    // response merge
    // ****************************************
    // at most one block answers a given address
    // idle blocks hold dack and rdat at zero
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sirRsp.dack <= 1'b0;
            sirRsp.rdat <= '0;
        end
        else
        begin
            sirRsp.dack <= ctrlRsp.dack | statusRsp.dack;
            sirRsp.rdat <= ctrlRsp.rdat | statusRsp.rdat;
        end
    end

endmodule

`default_nettype wire

// File: hw/csrPkg.sv
`default_nettype none

package csrPkg;

    // ****************************************
    // bus types
    // ****************************************
    typedef logic [15:0] sirAddr_t;
    typedef logic [31:0] sirData_t;
    typedef logic [7:0]  wavePos_t;
    typedef logic [15:0] field16_t;
    typedef logic [7:0]  field8_t;

    typedef struct packed {
        logic     sel;
        logic     read;
        sirAddr_t addr;
        sirData_t wdat;
    } sirReq_t;

    typedef struct packed {
        logic     dack;
        sirData_t rdat;
    } sirRsp_t;

    // settings driven to the datapath
    typedef struct packed {
        field16_t horizontalPitch;
        field16_t clutCpi;
        field16_t clutTasCpi;
        field16_t clutTasInr;
        field16_t adcTruncation;
        field8_t  clutMode;
        field8_t  clutSchSw;
        field8_t  clutTasAry;
        field8_t  rfftTruncation;
        logic     firEnable;
        logic     configTrigger;
        sirData_t calibrationIqA;
        sirData_t calibrationIqB;
    } ctrlFields_t;

    // ****************************************
    // address map
    // ****************************************
    localparam sirAddr_t ADDR_PITCH      = 16'h2000;
    localparam sirAddr_t ADDR_CLUT_CPI   = 16'h2004;
    localparam sirAddr_t ADDR_CLUT_MODE  = 16'h2008;
    localparam sirAddr_t ADDR_CLUT_SCH   = 16'h200C;
    localparam sirAddr_t ADDR_TAS_CPI    = 16'h2010;
    localparam sirAddr_t ADDR_TAS_ARY    = 16'h2014;
    localparam sirAddr_t ADDR_TAS_INR    = 16'h2018;
    localparam sirAddr_t ADDR_FIR_EN     = 16'h2048;
    localparam sirAddr_t ADDR_CFG_TRIG   = 16'h204C;
    localparam sirAddr_t ADDR_CAL_A      = 16'h2050;
    localparam sirAddr_t ADDR_CAL_B      = 16'h2054;
    localparam sirAddr_t ADDR_WAVE_POS   = 16'h2058;
    localparam sirAddr_t ADDR_ADC_TRUNC  = 16'h2F00;
    localparam sirAddr_t ADDR_RFFT_TRUNC = 16'h2F04;

    localparam int NUM_CTRL_REGS = 13;

    typedef logic [$clog2(NUM_CTRL_REGS)-1:0] ctrlIdx_t;

    // slot of each control register in the tables below
    localparam int IDX_PITCH      = 0;
    localparam int IDX_CLUT_CPI   = 1;
    localparam int IDX_CLUT_MODE  = 2;
    localparam int IDX_CLUT_SCH   = 3;
    localparam int IDX_TAS_CPI    = 4;
    localparam int IDX_TAS_ARY    = 5;
    localparam int IDX_TAS_INR    = 6;
    localparam int IDX_FIR_EN     = 7;
    localparam int IDX_CFG_TRIG   = 8;
    localparam int IDX_CAL_A      = 9;
    localparam int IDX_CAL_B      = 10;
    localparam int IDX_ADC_TRUNC  = 11;
    localparam int IDX_RFFT_TRUNC = 12;

    localparam sirAddr_t CTRL_ADDRS [NUM_CTRL_REGS] = '{
        ADDR_PITCH, ADDR_CLUT_CPI, ADDR_CLUT_MODE, ADDR_CLUT_SCH,
        ADDR_TAS_CPI, ADDR_TAS_ARY, ADDR_TAS_INR,
        ADDR_FIR_EN, ADDR_CFG_TRIG, ADDR_CAL_A, ADDR_CAL_B,
        ADDR_ADC_TRUNC, ADDR_RFFT_TRUNC
    };

    localparam sirData_t CTRL_RESETS [NUM_CTRL_REGS] = '{
        32'd1000, 32'd1, 32'd0, 32'd0,
        32'd1, 32'd0, 32'd1000,
        32'd0, 32'd0, 32'h0000_1000, 32'hFD78_0C32,
        32'd11, 32'd8
    };

endpackage

`default_nettype wire

// File: hw/csrTop.sv
`timescale 1ns/1ps
`default_nettype none

module csrTop
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire csrPkg::sirReq_t  sirReq,
    output csrPkg::sirRsp_t       sirRsp,
    output csrPkg::ctrlFields_t   ctrlFields,
    input  wire csrPkg::wavePos_t curWavePosition
);

    // partial answers of the two register blocks
    csrPkg::sirRsp_t ctrlRsp;
    csrPkg::sirRsp_t statusRsp;

    // ****************************************
    // register blocks decoding in parallel
    // ****************************************
    ctrlRegBank ctrlRegBank_i
    (
        .clk        (clk),
        .rst        (rst),
        .sirReq     (sirReq),
        .partRsp    (ctrlRsp),
        .ctrlFields (ctrlFields)
    );

    // wave position readback
    statusRegs statusRegs_i
    (
        .clk             (clk),
        .rst             (rst),
        .sirReq          (sirReq),
        .partRsp         (statusRsp),
        .curWavePosition (curWavePosition)
    );

    // ****************************************
    // bus response
    // ****************************************
    // last register stage gives two cycles from request to dack
    busResponder busResponder_i
    (
        .clk       (clk),
        .rst       (rst),
        .ctrlRsp   (ctrlRsp),
        .statusRsp (statusRsp),
        .sirRsp    (sirRsp)
    );

endmodule

`default_nettype wire

// File: hw/ctrlRegBank.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlRegBank
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire csrPkg::sirReq_t  sirReq,
    output csrPkg::sirRsp_t       partRsp,
    output csrPkg::ctrlFields_t   ctrlFields
);

    csrPkg::sirData_t regs [csrPkg::NUM_CTRL_REGS];

    logic             hit;
    csrPkg::ctrlIdx_t hitIdx;
    logic             wrEn;
    logic             rdEn;

    // ****************************************
    // address decode
    // ****************************************
    always_comb
    begin
        hit    = 1'b0;
        hitIdx = '0;
        for (int i = 0; i < csrPkg::NUM_CTRL_REGS; i++)
        begin
            if (sirReq.addr == csrPkg::CTRL_ADDRS[i])
            begin
                hit    = 1'b1;
                hitIdx = csrPkg::ctrlIdx_t'(i);
            end
        end
    end

    assign wrEn = sirReq.sel && !sirReq.read && hit;
    assign rdEn = sirReq.sel && sirReq.read && hit;

    // ****************************************
    // register storage
    // ****************************************
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < csrPkg::NUM_CTRL_REGS; i++)
            begin
                regs[i] <= csrPkg::CTRL_RESETS[i];
            end
        end
        else if (wrEn)
        begin
            regs[hitIdx] <= sirReq.wdat;
        end
    end

    // read data sees the value before any same-cycle write
    always_ff @(posedge clk)
    begin
        partRsp.rdat <= rdEn ? regs[hitIdx] : '0;
        if (rst)
        begin
            partRsp.dack <= 1'b0;
        end
        else
        begin
            partRsp.dack <= sirReq.sel && hit;
        end
    end

    // ****************************************
    // datapath fields
    // ****************************************
    // each field is the low bits of its word
    always_comb
    begin
        ctrlFields.horizontalPitch = csrPkg::field16_t'(regs[csrPkg::IDX_PITCH]);
        ctrlFields.clutCpi         = csrPkg::field16_t'(regs[csrPkg::IDX_CLUT_CPI]);
        ctrlFields.clutTasCpi      = csrPkg::field16_t'(regs[csrPkg::IDX_TAS_CPI]);
        ctrlFields.clutTasInr      = csrPkg::field16_t'(regs[csrPkg::IDX_TAS_INR]);
        ctrlFields.adcTruncation   = csrPkg::field16_t'(regs[csrPkg::IDX_ADC_TRUNC]);
        ctrlFields.clutMode        = csrPkg::field8_t'(regs[csrPkg::IDX_CLUT_MODE]);
        ctrlFields.clutSchSw       = csrPkg::field8_t'(regs[csrPkg::IDX_CLUT_SCH]);
        ctrlFields.clutTasAry      = csrPkg::field8_t'(regs[csrPkg::IDX_TAS_ARY]);
        ctrlFields.rfftTruncation  = csrPkg::field8_t'(regs[csrPkg::IDX_RFFT_TRUNC]);
        // single bit enables
        ctrlFields.firEnable       = regs[csrPkg::IDX_FIR_EN][0];
        ctrlFields.configTrigger   = regs[csrPkg::IDX_CFG_TRIG][0];
        ctrlFields.calibrationIqA  = regs[csrPkg::IDX_CAL_A];
        ctrlFields.calibrationIqB  = regs[csrPkg::IDX_CAL_B];
    end

endmodule

`default_nettype wire

// File: hw/statusRegs.sv
`timescale 1ns/1ps
`default_nettype none

module statusRegs
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire csrPkg::sirReq_t  sirReq,
    output csrPkg::sirRsp_t       partRsp,
    input  wire csrPkg::wavePos_t curWavePosition
);

    csrPkg::wavePos_t holdPos;
    logic             hit;

    assign hit = sirReq.sel && (sirReq.addr == csrPkg::ADDR_WAVE_POS);

    // wave position sampled on every edge
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            holdPos <= '0;
        end
        else
        begin
            holdPos <= curWavePosition;
        end
    end

    // writes are acknowledged but change nothing
    always_ff @(posedge clk)
    begin
        partRsp.rdat <= (hit && sirReq.read) ? csrPkg::sirData_t'(holdPos) : '0;
        if (rst)
        begin
            partRsp.dack <= 1'b0;
        end
        else
        begin
            partRsp.dack <= hit;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds and runs the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module csrTb -f tb.f -o csrSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/csrSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: tb.f
+incdir+testbench
hw/csrPkg.sv
hw/ctrlRegBank.sv
hw/statusRegs.sv
hw/busResponder.sv
hw/csrTop.sv
testbench/csrTb.sv

// File: testbench/csrModel.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// mirror of the thirteen control words
csrPkg::sirData_t mirror [csrPkg::NUM_CTRL_REGS];

task automatic resetMirror();
    for (int i = 0; i < csrPkg::NUM_CTRL_REGS; i++)
    begin
        mirror[i] = csrPkg::CTRL_RESETS[i];
    end
endtask

// slot of a control address or -1 when not a control register
function automatic int findSlot(input csrPkg::sirAddr_t addr);
    int slot;
    slot = -1;
    for (int i = 0; i < csrPkg::NUM_CTRL_REGS; i++)
    begin
        if (csrPkg::CTRL_ADDRS[i] == addr)
        begin
            slot = i;
        end
    end
    return slot;
endfunction

function automatic logic isMapped(input csrPkg::sirAddr_t addr);
    return (findSlot(addr) >= 0) || (addr == csrPkg::ADDR_WAVE_POS);
endfunction

// acknowledged answer carrying data
function automatic csrPkg::sirRsp_t ackWith(input csrPkg::sirData_t data);
    csrPkg::sirRsp_t rsp;
    rsp.dack = 1'b1;
    rsp.rdat = data;
    return rsp;
endfunction

// low bits of each mirrored word
function automatic csrPkg::ctrlFields_t expectFields();
    csrPkg::ctrlFields_t f;
    f.horizontalPitch = mirror[csrPkg::IDX_PITCH][15:0];
    f.clutCpi         = mirror[csrPkg::IDX_CLUT_CPI][15:0];
    f.clutTasCpi      = mirror[csrPkg::IDX_TAS_CPI][15:0];
    f.clutTasInr      = mirror[csrPkg::IDX_TAS_INR][15:0];
    f.adcTruncation   = mirror[csrPkg::IDX_ADC_TRUNC][15:0];
    f.clutMode        = mirror[csrPkg::IDX_CLUT_MODE][7:0];
    f.clutSchSw       = mirror[csrPkg::IDX_CLUT_SCH][7:0];
    f.clutTasAry      = mirror[csrPkg::IDX_TAS_ARY][7:0];
    f.rfftTruncation  = mirror[csrPkg::IDX_RFFT_TRUNC][7:0];
    f.firEnable       = mirror[csrPkg::IDX_FIR_EN][0];
    f.configTrigger   = mirror[csrPkg::IDX_CFG_TRIG][0];
    f.calibrationIqA  = mirror[csrPkg::IDX_CAL_A];
    f.calibrationIqB  = mirror[csrPkg::IDX_CAL_B];
    return f;
endfunction

`endif

// File: testbench/csrTb.sv
`timescale 1ns/1ps
`default_nettype none

module csrTb;

    localparam int ACK_TIMEOUT = 10;
    localparam int NUM_WRITES  = 40;
    localparam csrPkg::sirRsp_t NO_RSP = '0;

    logic                clk;
    logic                rst;
    csrPkg::sirReq_t     sirReq;
    csrPkg::sirRsp_t     sirRsp;
    csrPkg::ctrlFields_t ctrlFields;
    csrPkg::wavePos_t    curWavePosition;

    logic [31:0]         lcgState;
    csrPkg::sirRsp_t     gotRsp;
    csrPkg::sirData_t    data;
    csrPkg::sirData_t    waveWord;
    csrPkg::wavePos_t    wave;
    csrPkg::sirAddr_t    badAddr;
    int                  slot;
    int                  other;

    `include "csrModel.svh"

    csrTop csrTop_i
    (
        .clk             (clk),
        .rst             (rst),
        .sirReq          (sirReq),
        .sirRsp          (sirRsp),
        .ctrlFields      (ctrlFields),
        .curWavePosition (curWavePosition)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic csrPkg::sirReq_t makeReq(input logic read,
                                                input csrPkg::sirAddr_t addr,
                                                input csrPkg::sirData_t wdat);
        csrPkg::sirReq_t req;
        req.sel  = 1'b1;
        req.read = read;
        req.addr = addr;
        req.wdat = wdat;
        return req;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic checkRsp(input string name, input csrPkg::sirRsp_t expected,
                            input csrPkg::sirRsp_t actual);
        if (actual !== expected)
        begin
            failRun($sformatf("Fail %s: expected dack %0b rdat %h, actual dack %0b rdat %h",
                name, expected.dack, expected.rdat, actual.dack, actual.rdat));
        end
    endtask

    task automatic checkFields(input string name, input csrPkg::ctrlFields_t expected,
                               input csrPkg::ctrlFields_t actual);
        if (actual !== expected)
        begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // nextEdges is the edge count since the request at the next falling edge
    task automatic waitAck(input string name, input int nextEdges,
                           output csrPkg::sirRsp_t rsp);
        int edges;
        edges = nextEdges;
        @(negedge clk);
        while (!sirRsp.dack)
        begin
            if (edges >= ACK_TIMEOUT)
            begin
                failRun($sformatf("%s: no acknowledge within %0d cycles", name, ACK_TIMEOUT));
            end
            edges++;
            @(negedge clk);
        end
        if (edges != 2)
        begin
            failRun($sformatf("Fail %s latency: expected 2, actual %0d", name, edges));
        end
        rsp = sirRsp;
    endtask

    // one request, its answer, then dack must drop
    task automatic transfer(input string name, input csrPkg::sirReq_t req,
                            input csrPkg::sirRsp_t expected);
        csrPkg::sirRsp_t rsp;
        @(posedge clk);
        sirReq <= req;
        @(posedge clk);
        sirReq <= '0;
        waitAck(name, 1, rsp);
        checkRsp(name, expected, rsp);
        @(negedge clk);
        checkRsp({name, " pulse end"}, NO_RSP, sirRsp);
    endtask

    initial
    begin
        lcgState = 32'd35856;
        rst <= 1'b1;
        sirReq <= '0;
        curWavePosition <= '0;
        resetMirror();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // ****************************************
        // reset values
        // ****************************************
        @(negedge clk);
        checkFields("reset fields", expectFields(), ctrlFields);
        for (int i = 0; i < csrPkg::NUM_CTRL_REGS; i++)
        begin
            transfer($sformatf("reset read %0d", i),
                makeReq(1'b1, csrPkg::CTRL_ADDRS[i], '0), ackWith(mirror[i]));
        end

        // random writes with readback
        for (int n = 0; n < NUM_WRITES; n++)
        begin
            slot = int'(lcgNext() % csrPkg::NUM_CTRL_REGS);
            data = lcgNext();
            transfer($sformatf("random write %0d", n),
                makeReq(1'b0, csrPkg::CTRL_ADDRS[slot], data), ackWith('0));
            mirror[slot] = data;
            checkFields($sformatf("fields after write %0d", n), expectFields(), ctrlFields);
            transfer($sformatf("read back %0d", n),
                makeReq(1'b1, csrPkg::CTRL_ADDRS[slot], '0), ackWith(mirror[slot]));
        end

        // ****************************************
        // wave position status
        // ****************************************
        wave = csrPkg::wavePos_t'(lcgNext());
        waveWord = {24'd0, wave};
        @(posedge clk);
        curWavePosition <= wave;
        repeat (2) @(posedge clk);
        transfer("wave read", makeReq(1'b1, csrPkg::ADDR_WAVE_POS, '0), ackWith(waveWord));
        transfer("wave write", makeReq(1'b0, csrPkg::ADDR_WAVE_POS, lcgNext()), ackWith('0));
        transfer("wave read again", makeReq(1'b1, csrPkg::ADDR_WAVE_POS, '0),
            ackWith(waveWord));
        checkFields("fields after wave write", expectFields(), ctrlFields);

        // back to back write and read
        slot = int'(lcgNext() % csrPkg::NUM_CTRL_REGS);
        other = (slot + 1 + int'(lcgNext() % (csrPkg::NUM_CTRL_REGS - 1)))
            % csrPkg::NUM_CTRL_REGS;
        data = lcgNext();
        @(posedge clk);
        sirReq <= makeReq(1'b0, csrPkg::CTRL_ADDRS[slot], data);
        @(posedge clk);
        sirReq <= makeReq(1'b1, csrPkg::CTRL_ADDRS[other], '0);
        @(posedge clk);
        sirReq <= '0;
        mirror[slot] = data;
        waitAck("pair write", 2, gotRsp);
        checkRsp("pair write", ackWith('0), gotRsp);
        waitAck("pair read", 2, gotRsp);
        checkRsp("pair read", ackWith(mirror[other]), gotRsp);
        @(negedge clk);
        checkRsp("pair end", NO_RSP, sirRsp);
        checkFields("pair fields", expectFields(), ctrlFields);

        // ****************************************
        // unmapped address
        // ****************************************
        // a write, so that a decode fault would show in the fields
        badAddr = csrPkg::sirAddr_t'(lcgNext());
        while (isMapped(badAddr))
        begin
            badAddr = badAddr + 16'd1;
        end
        data = lcgNext();
        @(posedge clk);
        sirReq <= makeReq(1'b0, badAddr, data);
        @(posedge clk);
        sirReq <= '0;
        repeat (3)
        begin
            @(negedge clk);
            checkRsp("unmapped", NO_RSP, sirRsp);
        end
        checkFields("unmapped fields", expectFields(), ctrlFields);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
